//--- rtl/isaPkg.sv
package isaPkg;

	localparam int instrWidth = 16;

	// each register field is given by the low bit of its nibble
	localparam int fieldWidth = 4;
	localparam int fieldD = 0;
	localparam int fieldB = 4;
	localparam int fieldA = 8;

	// IDs are named by their code
	typedef enum logic [4:0] {
		id00, id01, id02, id03, id04, id05, id06, id07,
		id08, id09, id0A, id0B, id0C, id0D, id0E, id0F,
		id10, id11, id12, id13, id14, id15, id16, id17,
		id18, id19, id1A, id1B, id1C, id1D, id1E, id1F
	} instrIdT;

	localparam int specialWidth = 3;
	localparam int specJump = 0;
	localparam int specMemRead = 1;
	localparam int specMemWrite = 2;

endpackage

//--- rtl/renamePkg.sv
package renamePkg;

	// each renamed architectural register has a shadow copy at index + archRegs
	localparam int archRegs = 16;

	// the status register sits just above the architectural registers
	localparam int statusReg = 16;

	localparam int logMaskWidth = 17;

	// two copies of every register plus the status bit on top
	localparam int physMaskWidth = 33;

	// registers 0 and 1 keep a single copy
	localparam int firstRenamed = 2;

endpackage

//--- rtl/dependDecoder.sv
`timescale 1ns/1ps

module dependDecoder (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              inValid,
	input  logic [isaPkg::instrWidth-1:0]     instruction,
	input  logic                              decReady,
	output logic                              inReady,
	output logic                              decValid,
	output isaPkg::instrIdT                   decId,
	output logic [renamePkg::logMaskWidth-1:0] decRead,
	output logic [renamePkg::logMaskWidth-1:0] decWrite,
	output logic [isaPkg::specialWidth-1:0]   decSpecial
);

	import isaPkg::*;
	import renamePkg::*;

	logic [fieldWidth-1:0] regD;
	logic [fieldWidth-1:0] regB;
	logic [fieldWidth-1:0] regA;
	instrIdT idNext;
	logic [logMaskWidth-1:0] readNext;
	logic [logMaskWidth-1:0] writeNext;
	logic [specialWidth-1:0] specNext;

	assign regD = instruction[fieldD +: fieldWidth];
	assign regB = instruction[fieldB +: fieldWidth];
	assign regA = instruction[fieldA +: fieldWidth];

	// an all-ones top nibble selects the extended half of the ID space
	assign idNext = (&instruction[instrWidth-1 -: fieldWidth]) ?
		instrIdT'({1'b1, regA}) :
		instrIdT'({1'b0, instruction[instrWidth-1 -: fieldWidth]});

	always_comb begin
		readNext = '0;
		writeNext = '0;
		specNext = '0;
		case (idNext)
			id00: begin
				writeNext[regD] = 1'b1;
			end
			id01: begin
				readNext[regD] = 1'b1;
				writeNext[regD] = 1'b1;
			end
			id02: begin
				readNext[1] = 1'b1;
				writeNext[regD] = 1'b1;
				specNext[specMemRead] = 1'b1;
			end
			id03: begin
				readNext[1] = 1'b1;
				readNext[regD] = 1'b1;
				specNext[specMemWrite] = 1'b1;
			end
			id04, id05, id06, id0A, id0C, id0D: begin
				readNext[regA] = 1'b1;
				readNext[regB] = 1'b1;
				writeNext[regD] = 1'b1;
			end
			id07: begin
				readNext[regA] = 1'b1;
				readNext[regB] = 1'b1;
				readNext[regD] = 1'b1;
				writeNext[regB] = 1'b1;
				writeNext[regD] = 1'b1;
			end
			id08: begin
				readNext[regA] = 1'b1;
				readNext[regB] = 1'b1;
				writeNext[regD] = 1'b1;
				specNext[specMemRead] = 1'b1;
			end
			id09: begin
				readNext[regA] = 1'b1;
				readNext[regB] = 1'b1;
				readNext[regD] = 1'b1;
				specNext[specMemWrite] = 1'b1;
			end
			id0B: begin
				readNext[regA] = 1'b1;
				readNext[regB] = 1'b1;
				readNext[15] = 1'b1;
				writeNext[regD] = 1'b1;
				writeNext[15] = 1'b1;
			end
			id0E: begin
				readNext[regA] = 1'b1;
				readNext[regB] = 1'b1;
				readNext[regD] = 1'b1;
				specNext[specJump] = 1'b1;
			end
			id10: begin
				readNext[regD] = 1'b1;
				readNext[statusReg] = 1'b1;
				writeNext[statusReg] = 1'b1;
				specNext[specMemWrite] = 1'b1;
			end
			id11: begin
				readNext[regD] = 1'b1;
				readNext[regB] = 1'b1;
				readNext[statusReg] = 1'b1;
				writeNext[statusReg] = 1'b1;
				specNext[specMemWrite] = 1'b1;
			end
			id12: begin
				readNext[statusReg] = 1'b1;
				writeNext[regD] = 1'b1;
				writeNext[statusReg] = 1'b1;
				specNext[specMemRead] = 1'b1;
			end
			id13: begin
				readNext[statusReg] = 1'b1;
				writeNext[regD] = 1'b1;
				writeNext[regB] = 1'b1;
				writeNext[statusReg] = 1'b1;
				specNext[specMemRead] = 1'b1;
			end
			id14, id15, id16: begin
				readNext[regB] = 1'b1;
				writeNext[regD] = 1'b1;
			end
			id17: begin
				readNext[regB] = 1'b1;
				readNext[regD] = 1'b1;
				writeNext[regD] = 1'b1;
			end
			id18: begin
				readNext[regB] = 1'b1;
				readNext[regD] = 1'b1;
				readNext[13] = 1'b1;
				readNext[14] = 1'b1;
				writeNext[13] = 1'b1;
				writeNext[14] = 1'b1;
			end
			id19: begin
				readNext[regB] = 1'b1;
				readNext[regD] = 1'b1;
				writeNext[regB] = 1'b1;
				writeNext[regD] = 1'b1;
			end
			id1A: begin
				readNext[regB] = 1'b1;
				readNext[regD] = 1'b1;
				readNext[0] = 1'b1;
				readNext[1] = 1'b1;
				readNext[statusReg] = 1'b1;
				writeNext[0] = 1'b1;
				writeNext[statusReg] = 1'b1;
				specNext[specJump] = 1'b1;
				specNext[specMemWrite] = 1'b1;
			end
			id1B: begin
				readNext[0] = 1'b1;
				writeNext[0] = 1'b1;
				writeNext[1] = 1'b1;
				writeNext[statusReg] = 1'b1;
				specNext[specJump] = 1'b1;
				specNext[specMemRead] = 1'b1;
			end
			id1C: begin
				readNext[regB] = 1'b1;
				readNext[13] = 1'b1;
				writeNext[regD] = 1'b1;
				specNext[specMemRead] = 1'b1;
			end
			id1D: begin
				readNext[regD] = 1'b1;
				readNext[regB] = 1'b1;
				readNext[13] = 1'b1;
				specNext[specMemWrite] = 1'b1;
			end
			id1E: begin
				readNext[regD] = 1'b1;
				readNext[regB] = 1'b1;
				specNext[specJump] = 1'b1;
			end
			id1F: begin
				readNext[regD] = 1'b1;
				readNext[statusReg] = 1'b1;
				writeNext[regD] = 1'b1;
				writeNext[statusReg] = 1'b1;
			end
			// id0F cannot be formed from any word and keeps the empty masks
			default: ;
		endcase
	end

	assign inReady = !decValid || decReady;

	always_ff @(posedge clock) begin
		if (reset) begin
			decValid <= 1'b0;
		end else if (inReady) begin
			decValid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			decId <= idNext;
			decRead <= readNext;
			decWrite <= writeNext;
			decSpecial <= specNext;
		end
	end

	noImpossibleId: assert property (@(posedge clock) disable iff (reset)
		decValid |-> decId != id0F);

	// a stalled item must not change before the rename stage takes it
	holdWhileStalled: assert property (@(posedge clock) disable iff (reset)
		decValid && !decReady |=> decValid && $stable({decId, decRead, decWrite, decSpecial}));

endmodule

//--- rtl/renameStage.sv
`timescale 1ns/1ps

module renameStage (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               decValid,
	input  isaPkg::instrIdT                    decId,
	input  logic [renamePkg::logMaskWidth-1:0]  decRead,
	input  logic [renamePkg::logMaskWidth-1:0]  decWrite,
	input  logic [isaPkg::specialWidth-1:0]    decSpecial,
	input  logic                               outReady,
	output logic                               decReady,
	output logic                               outValid,
	output isaPkg::instrIdT                    instrId,
	output logic [renamePkg::physMaskWidth-1:0] readMask,
	output logic [renamePkg::physMaskWidth-1:0] writeMask,
	output logic [isaPkg::specialWidth-1:0]    special,
	output logic [renamePkg::archRegs-1:0]     renameState
);

	import renamePkg::*;

	logic [archRegs-1:0] stateNext;
	logic [physMaskWidth-1:0] readNext;
	logic [physMaskWidth-1:0] writeNext;

	// renameState is the live state and also the state reported with the output item
	always_comb begin
		readNext = '0;
		writeNext = '0;
		stateNext = renameState;
		for (int r = 0; r < firstRenamed; r++) begin
			readNext[r] = decRead[r];
			writeNext[r] = decWrite[r];
		end
		for (int r = firstRenamed; r < archRegs; r++) begin
			// a pure write allocates the other copy, read-modify-write stays put
			stateNext[r] = renameState[r] ^ (decWrite[r] && !decRead[r]);
			if (renameState[r])
				readNext[r + archRegs] = decRead[r];
			else
				readNext[r] = decRead[r];
			if (stateNext[r])
				writeNext[r + archRegs] = decWrite[r];
			else
				writeNext[r] = decWrite[r];
		end
		readNext[physMaskWidth-1] = decRead[statusReg];
		writeNext[physMaskWidth-1] = decWrite[statusReg];
	end

	assign decReady = !outValid || outReady;

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
			renameState <= '0;
		end else if (decReady) begin
			outValid <= decValid;
			if (decValid)
				renameState <= stateNext;
		end
	end

	always_ff @(posedge clock) begin
		if (decValid && decReady) begin
			instrId <= decId;
			readMask <= readNext;
			writeMask <= writeNext;
			special <= decSpecial;
		end
	end

	oneCopyPerReg: assert property (@(posedge clock) disable iff (reset)
		outValid |-> (readMask[archRegs-1:0] & readMask[2*archRegs-1:archRegs]) == '0 &&
		(writeMask[archRegs-1:0] & writeMask[2*archRegs-1:archRegs]) == '0);

	// registers 0 and 1 have no shadow copy
	noShadowLowRegs: assert property (@(posedge clock) disable iff (reset)
		outValid |-> readMask[archRegs +: firstRenamed] == '0 &&
		writeMask[archRegs +: firstRenamed] == '0);

endmodule

//--- rtl/dependencyGen.sv
`timescale 1ns/1ps

module dependencyGen (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               inValid,
	input  logic [isaPkg::instrWidth-1:0]      instruction,
	output logic                               inReady,
	input  logic                               outReady,
	output logic                               outValid,
	output isaPkg::instrIdT                    instrId,
	output logic [renamePkg::physMaskWidth-1:0] readMask,
	output logic [renamePkg::physMaskWidth-1:0] writeMask,
	output logic [isaPkg::specialWidth-1:0]    special,
	output logic [renamePkg::archRegs-1:0]     renameState
);

	import isaPkg::*;
	import renamePkg::*;

	logic decValid;
	logic decReady;
	instrIdT decId;
	logic [logMaskWidth-1:0] decRead;
	logic [logMaskWidth-1:0] decWrite;
	logic [specialWidth-1:0] decSpecial;

	dependDecoder decoder (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.instruction(instruction),
		.decReady(decReady),
		.inReady(inReady),
		.decValid(decValid),
		.decId(decId),
		.decRead(decRead),
		.decWrite(decWrite),
		.decSpecial(decSpecial)
	);

	renameStage rename (
		.clock(clock),
		.reset(reset),
		.decValid(decValid),
		.decId(decId),
		.decRead(decRead),
		.decWrite(decWrite),
		.decSpecial(decSpecial),
		.outReady(outReady),
		.decReady(decReady),
		.outValid(outValid),
		.instrId(instrId),
		.readMask(readMask),
		.writeMask(writeMask),
		.special(special),
		.renameState(renameState)
	);

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int period = 100
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

endmodule

//--- testbench/dependencyGenTb.sv
`timescale 1ns/1ps

module dependencyGenTb;

	import isaPkg::*;
	import renamePkg::*;

	localparam int period = 100;
	localparam int maxRows = 40;

	logic clock;
	logic reset;
	logic inValid;
	logic [instrWidth-1:0] instruction;
	logic inReady;
	logic outReady;
	logic outValid;
	instrIdT instrId;
	logic [physMaskWidth-1:0] readMask;
	logic [physMaskWidth-1:0] writeMask;
	logic [specialWidth-1:0] special;
	logic [archRegs-1:0] renameState;

	string rowName [maxRows];
	logic [instrWidth-1:0] rowWord [maxRows];
	logic [4:0] rowId [maxRows];
	logic [specialWidth-1:0] rowSpecial [maxRows];
	int rows = 0;

	// expected results in issue order
	int expRow [$];
	logic [physMaskWidth-1:0] expRead [$];
	logic [physMaskWidth-1:0] expWrite [$];
	logic [archRegs-1:0] expState [$];

	logic [archRegs-1:0] modelState;
	logic [31:0] seed;
	logic randomReady;
	logic stalled;
	logic [89:0] heldData;
	int mismatches = 0;
	int otherErrors = 0;

	clockGen #(.period(period)) clocks (.clock(clock));

	dependencyGen DUT (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.instruction(instruction),
		.inReady(inReady),
		.outReady(outReady),
		.outValid(outValid),
		.instrId(instrId),
		.readMask(readMask),
		.writeMask(writeMask),
		.special(special),
		.renameState(renameState)
	);

	task automatic addRow(input string name, input logic [instrWidth-1:0] word,
			input logic [4:0] id, input logic [specialWidth-1:0] spec);
		rowName[rows] = name;
		rowWord[rows] = word;
		rowId[rows] = id;
		rowSpecial[rows] = spec;
		rows++;
	endtask

	// {readA, readB, readD, writeB, writeD, fixed reads, fixed writes}
	function automatic logic [38:0] ruleFor(input logic [4:0] id);
		case (id)
			5'h00: ruleFor = {5'b00001, 17'h00000, 17'h00000};
			5'h01: ruleFor = {5'b00101, 17'h00000, 17'h00000};
			5'h02: ruleFor = {5'b00001, 17'h00002, 17'h00000};
			5'h03: ruleFor = {5'b00100, 17'h00002, 17'h00000};
			5'h04, 5'h05, 5'h06, 5'h08, 5'h0A, 5'h0C, 5'h0D:
				ruleFor = {5'b11001, 17'h00000, 17'h00000};
			5'h07: ruleFor = {5'b11111, 17'h00000, 17'h00000};
			5'h09, 5'h0E: ruleFor = {5'b11100, 17'h00000, 17'h00000};
			5'h0B: ruleFor = {5'b11001, 17'h08000, 17'h08000};
			5'h10: ruleFor = {5'b00100, 17'h10000, 17'h10000};
			5'h11: ruleFor = {5'b01100, 17'h10000, 17'h10000};
			5'h12: ruleFor = {5'b00001, 17'h10000, 17'h10000};
			5'h13: ruleFor = {5'b00011, 17'h10000, 17'h10000};
			5'h14, 5'h15, 5'h16: ruleFor = {5'b01001, 17'h00000, 17'h00000};
			5'h17: ruleFor = {5'b01101, 17'h00000, 17'h00000};
			5'h18: ruleFor = {5'b01100, 17'h06000, 17'h06000};
			5'h19: ruleFor = {5'b01111, 17'h00000, 17'h00000};
			5'h1A: ruleFor = {5'b01100, 17'h10003, 17'h10001};
			5'h1B: ruleFor = {5'b00000, 17'h00001, 17'h10003};
			5'h1C: ruleFor = {5'b01001, 17'h02000, 17'h00000};
			5'h1D: ruleFor = {5'b01100, 17'h02000, 17'h00000};
			5'h1E: ruleFor = {5'b01100, 17'h00000, 17'h00000};
			5'h1F: ruleFor = {5'b00101, 17'h10000, 17'h10000};
			default: ruleFor = '0;
		endcase
	endfunction

	// the reference model runs once for every accepted instruction
	task automatic predict(input int i);
		logic [38:0] rule;
		logic [16:0] rd;
		logic [16:0] wr;
		logic [32:0] physRead;
		logic [32:0] physWrite;
		int a;
		int b;
		int d;
		rule = ruleFor(rowId[i]);
		d = rowWord[i][3:0];
		b = rowWord[i][7:4];
		a = rowWord[i][11:8];
		rd = rule[33:17] | (17'(rule[38]) << a) | (17'(rule[37]) << b) | (17'(rule[36]) << d);
		wr = rule[16:0] | (17'(rule[35]) << b) | (17'(rule[34]) << d);
		physRead = '0;
		physWrite = '0;
		for (int r = 0; r < 16; r++) begin
			if (r < 2) begin
				physRead[r] = rd[r];
				physWrite[r] = wr[r];
			end else begin
				// a set state bit selects the upper copy at r + 16
				physRead[r + 16 * modelState[r]] = rd[r];
				modelState[r] = modelState[r] ^ (wr[r] & ~rd[r]);
				physWrite[r + 16 * modelState[r]] = wr[r];
			end
		end
		physRead[32] = rd[16];
		physWrite[32] = wr[16];
		expRow.push_back(i);
		expRead.push_back(physRead);
		expWrite.push_back(physWrite);
		expState.push_back(modelState);
	endtask

	task automatic compare(input string name, input string field,
			input logic [32:0] expected, input logic [32:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
			mismatches++;
		end
	endtask

	task automatic checkOutput();
		int i;
		if (expRow.size() == 0) begin
			$display("an output item arrived with no instruction pending at %0t", $time);
			otherErrors++;
		end else begin
			i = expRow.pop_front();
			compare(rowName[i], "instrId", rowId[i], instrId);
			compare(rowName[i], "special", rowSpecial[i], special);
			compare(rowName[i], "readMask", expRead.pop_front(), readMask);
			compare(rowName[i], "writeMask", expWrite.pop_front(), writeMask);
			compare(rowName[i], "renameState", expState.pop_front(), renameState);
		end
	endtask

	// the monitor samples outputs on the falling edge
	always @(negedge clock) begin
		if (reset) begin
			stalled = 1'b0;
		end else begin
			if (stalled && (!outValid ||
					{instrId, readMask, writeMask, special, renameState} !== heldData)) begin
				$display("output item changed while stalled at %0t", $time);
				otherErrors++;
			end
			stalled = outValid && !outReady;
			heldData = {instrId, readMask, writeMask, special, renameState};
			if (outValid && outReady)
				checkOutput();
		end
	end

	always @(posedge clock) begin
		#5;
		outReady = randomReady ? (($random(seed) & 32'd1) != 0) : 1'b1;
	end

	task automatic applyReset();
		reset = 1'b1;
		repeat (8) @(posedge clock);
		#5;
		reset = 1'b0;
		modelState = '0;
	endtask

	task automatic driveRow(input int i);
		logic taken;
		taken = 1'b0;
		instruction = rowWord[i];
		inValid = 1'b1;
		while (!taken) begin
			@(negedge clock);
			taken = inReady;
			@(posedge clock);
			#5;
		end
		inValid = 1'b0;
		predict(i);
	endtask

	task automatic drain();
		while (expRow.size() != 0)
			@(posedge clock);
		repeat (4) @(posedge clock);
		#5;
	endtask

	task automatic watchdog();
		#(period * (2 * rows * 4 + 50));
		$display("timeout: outputs stopped arriving, %0d items still pending", expRow.size());
		$display("Result: FAILED");
		$finish;
	endtask

	initial begin
		reset = 1'b1;
		inValid = 1'b0;
		instruction = '0;
		outReady = 1'b1;
		randomReady = 1'b0;
		modelState = '0;
		seed = 32'h412a_c3cc;
		addRow("id00 write r5", 16'h0005, 5'h00, 3'b000);
		addRow("id01 rmw r5", 16'h1005, 5'h01, 3'b000);
		addRow("id02 load r5", 16'h2005, 5'h02, 3'b010);
		addRow("id03 store r5", 16'h3005, 5'h03, 3'b100);
		addRow("id04 write r5", 16'h4235, 5'h04, 3'b000);
		addRow("id05 write r5", 16'h5675, 5'h05, 3'b000);
		addRow("id06 write r5", 16'h6125, 5'h06, 3'b000);
		addRow("id07 rmw r4 r6", 16'h7346, 5'h07, 3'b000);
		addRow("id08 low regs", 16'h8015, 5'h08, 3'b010);
		addRow("id09 store", 16'h9ABC, 5'h09, 3'b100);
		addRow("id0A rmw r5", 16'hA5B5, 5'h0A, 3'b000);
		addRow("id0B r15", 16'hB127, 5'h0B, 3'b000);
		addRow("id0C write r5", 16'hC895, 5'h0C, 3'b000);
		addRow("id0D write r15", 16'hDE5F, 5'h0D, 3'b000);
		addRow("id0E jump", 16'hE555, 5'h0E, 3'b001);
		addRow("id10 status", 16'hF005, 5'h10, 3'b100);
		addRow("id11 status", 16'hF1A5, 5'h11, 3'b100);
		addRow("id12 status load", 16'hF205, 5'h12, 3'b010);
		addRow("id13 two writes", 16'hF385, 5'h13, 3'b010);
		addRow("id14 write r5", 16'hF465, 5'h14, 3'b000);
		addRow("id15 write r5", 16'hF5C5, 5'h15, 3'b000);
		addRow("id16 write r5", 16'hF625, 5'h16, 3'b000);
		addRow("id17 rmw r5", 16'hF735, 5'h17, 3'b000);
		addRow("id18 r13 r14", 16'hF8D2, 5'h18, 3'b000);
		addRow("id19 rmw r5", 16'hF955, 5'h19, 3'b000);
		addRow("id1A jump store", 16'hFA51, 5'h1A, 3'b101);
		addRow("id1B jump load", 16'hFB00, 5'h1B, 3'b011);
		addRow("id1C load r13", 16'hFC95, 5'h1C, 3'b010);
		addRow("id1D store r13", 16'hFD5E, 5'h1D, 3'b100);
		addRow("id1E jump", 16'hFE05, 5'h1E, 3'b001);
		addRow("id1F status rmw", 16'hFF05, 5'h1F, 3'b000);
		addRow("write r5 again", 16'h0005, 5'h00, 3'b000);
		addRow("write r5 once more", 16'h0005, 5'h00, 3'b000);
		addRow("read r5 last copy", 16'h4500, 5'h04, 3'b000);
		fork
			watchdog();
		join_none
		applyReset();
		for (int i = 0; i < rows; i++)
			driveRow(i);
		drain();
		// second reset with renamed registers still live in the state
		applyReset();
		compare("second reset", "renameState", '0, renameState);
		randomReady = 1'b1;
		for (int i = 0; i < rows; i++)
			driveRow(i);
		drain();
		$display("errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches + otherErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- compile.f
rtl/isaPkg.sv
rtl/renamePkg.sv
rtl/dependDecoder.sv
rtl/renameStage.sv
rtl/dependencyGen.sv
testbench/clockGen.sv
testbench/dependencyGenTb.sv

//--- Bender.yml
package:
  name: dependency_gen

sources:
  - files:
      - rtl/isaPkg.sv
      - rtl/renamePkg.sv
      - rtl/dependDecoder.sv
      - rtl/renameStage.sv
      - rtl/dependencyGen.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/dependencyGenTb.sv
